// File: verilog.f
source/fu_pkg.sv
source/issue_port.sv
source/op_queue.sv
source/op_logic.sv
source/iter_mul.sv
source/exec_unit.sv
source/fu_top.sv
verification/fu_sva.sv
verification/fu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert --top-module fu_tb \
	-f verilog.f --Mdir obj_dir -o fu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/fu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished"
exit 0

// File: verification/fu_tb.sv
module fu_tb;

	localparam int NUM = 25;
	// Entries from here on form the back-pressure group
	localparam int BP_FIRST = 19;
	localparam int LIMIT = NUM * (fu_pkg::MUL_STEPS + 20);

	logic                   clk;
	logic                   rst;
	logic                   issue_req;
	fu_pkg::op_t            issue_op;
	fu_pkg::cmb_t           issue_cmb;
	logic [fu_pkg::WID-1:0] issue_a;
	logic [fu_pkg::WID-1:0] issue_b;
	logic [fu_pkg::WID-1:0] issue_c;
	logic                   issue_ack;
	logic                   result_req;
	logic                   result_ack;
	logic [fu_pkg::WID-1:0] result_data;

	// Stimulus and expected-value table
	fu_pkg::op_t            tbl_op  [NUM];
	fu_pkg::cmb_t           tbl_cmb [NUM];
	logic [fu_pkg::WID-1:0] tbl_a   [NUM];
	logic [fu_pkg::WID-1:0] tbl_b   [NUM];
	logic [fu_pkg::WID-1:0] tbl_c   [NUM];
	logic [fu_pkg::WID-1:0] tbl_exp [NUM];

	int     n_entries;
	int     issued;
	int     seen;
	int     bp_cycles;
	int     cycles;
	integer seed;

	fu_top dut0 (
		.clk(clk), .rst(rst),
		.issue_req(issue_req), .issue_op(issue_op), .issue_cmb(issue_cmb),
		.issue_a(issue_a), .issue_b(issue_b), .issue_c(issue_c),
		.issue_ack(issue_ack),
		.result_req(result_req), .result_ack(result_ack), .result_data(result_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit sized for every entry being a worst case multiply
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Checks failed");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", LIMIT);
		end
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_result(input int idx, input fu_pkg::op_t op, input fu_pkg::cmb_t cmb,
		input logic [fu_pkg::WID-1:0] exp, input logic [fu_pkg::WID-1:0] act);
		if (act !== exp) begin
			$display("ERR %0t: entry %0d %s/%s expected %h got %h",
				$time, idx, op.name(), cmb.name(), exp, act);
			$display("Checks failed");
			$fatal(1, "Result mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic act, input logic exp);
		if (act !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, act, exp);
			$display("Checks failed");
			$fatal(1, "Level mismatch");
		end
	endtask

	task automatic add_entry(input fu_pkg::op_t op, input fu_pkg::cmb_t cmb,
		input logic [fu_pkg::WID-1:0] a, input logic [fu_pkg::WID-1:0] b,
		input logic [fu_pkg::WID-1:0] c, input logic [fu_pkg::WID-1:0] exp);
		tbl_op[n_entries]  = op;
		tbl_cmb[n_entries] = cmb;
		tbl_a[n_entries]   = a;
		tbl_b[n_entries]   = b;
		tbl_c[n_entries]   = c;
		tbl_exp[n_entries] = exp;
		n_entries++;
	endtask

	// ========================================================================
	// Four-phase driver and monitor
	// ========================================================================

	// Issue side sender that also checks the queue refuses while five are outstanding
	task automatic send_ops(input int first, input int last);
		int i;
		for (i = first; i < last; i++) begin
			issue_op  = tbl_op[i];
			issue_cmb = tbl_cmb[i];
			issue_a   = tbl_a[i];
			issue_b   = tbl_b[i];
			issue_c   = tbl_c[i];
			issue_req = 1'b1;
			do begin
				@(posedge clk);
				#10;
				if (issued - seen >= 5) begin
					bp_cycles++;
					check_flag("issue_ack with five outstanding", issue_ack, 1'b0);
				end
			end while (!issue_ack);
			issued++;
			issue_req = 1'b0;
			while (issue_ack) begin
				@(posedge clk);
				#10;
			end
		end
	endtask

	// Writeback side receiver with a random acknowledge delay of 0 to 3 cycles
	task automatic collect_results(input int first, input int last, input logic hold);
		int i;
		int delay;
		for (i = first; i < last; i++) begin
			while (!result_req) begin
				@(posedge clk);
				#10;
			end
			// The first result of the group sits unacknowledged so the queue fills
			if (hold && i == first) begin
				repeat (12) @(posedge clk);
				#10;
			end
			check_result(i, tbl_op[i], tbl_cmb[i], tbl_exp[i], result_data);
			seen++;
			delay = $random(seed) & 3;
			repeat (delay) begin
				@(posedge clk);
				#10;
			end
			result_ack = 1'b1;
			do begin
				@(posedge clk);
				#10;
			end while (result_req);
			result_ack = 1'b0;
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		rst        = 1'b1;
		issue_req  = 1'b0;
		issue_op   = fu_pkg::OP_ADD;
		issue_cmb  = fu_pkg::CMB_AND;
		issue_a    = '0;
		issue_b    = '0;
		issue_c    = '0;
		result_ack = 1'b0;
		cycles     = 0;
		issued     = 0;
		seen       = 0;
		bp_cycles  = 0;
		n_entries  = 0;
		seed       = 32'h926e626b;

		// Three-operand forms, sub and majority
		add_entry(fu_pkg::OP_ADD, fu_pkg::CMB_AND, 64'hF0, 64'h3C, 64'hF0F, 64'h10C);
		add_entry(fu_pkg::OP_AND, fu_pkg::CMB_OR, 64'hF0, 64'h3C, 64'hF0F, 64'hF3F);
		add_entry(fu_pkg::OP_OR, fu_pkg::CMB_EOR, 64'hF0, 64'h3C, 64'hF0F, 64'hFF3);
		add_entry(fu_pkg::OP_EOR, fu_pkg::CMB_ADD, 64'hF0, 64'h3C, 64'hF0F, 64'hFDB);
		add_entry(fu_pkg::OP_ADD, fu_pkg::CMB_ADD, '1, 64'h1, 64'h5, 64'h5);
		add_entry(fu_pkg::OP_MUL, fu_pkg::CMB_AND, 64'h1234, 64'h0, 64'h0, 64'h0);
		add_entry(fu_pkg::OP_SUB, fu_pkg::CMB_AND, 64'h64, 64'h10, 64'h4, 64'h50);
		add_entry(fu_pkg::OP_SUB, fu_pkg::CMB_AND, 64'h0, 64'h1, 64'h1, 64'hFFFF_FFFF_FFFF_FFFE);
		add_entry(fu_pkg::OP_MUL, fu_pkg::CMB_AND, 64'h1234_5678, 64'h1, 64'h0, 64'h1234_5678);
		add_entry(fu_pkg::OP_MAJ, fu_pkg::CMB_AND, 64'hF0F0, 64'hFF00, 64'h0FF0, 64'hFFF0);
		// Minus one against one orders differently signed and unsigned
		add_entry(fu_pkg::OP_CMP, fu_pkg::CMB_OR, '1, 64'h1, 64'h0, 64'h6);
		add_entry(fu_pkg::OP_CMPU, fu_pkg::CMB_OR, '1, 64'h1, 64'h0, 64'h0);
		add_entry(fu_pkg::OP_MUL, fu_pkg::CMB_AND, 64'h1234_5678, 64'h1_0000, 64'h0,
			64'h1234_5678_0000);
		add_entry(fu_pkg::OP_CMP, fu_pkg::CMB_EOR, 64'h5, 64'h5, 64'hFF, 64'hFA);
		add_entry(fu_pkg::OP_CMPU, fu_pkg::CMB_ADD, 64'h3, 64'h7, 64'h100, 64'h106);
		add_entry(fu_pkg::OP_MUL, fu_pkg::CMB_AND, 64'h3, 64'h8000_0000_0000_0000, 64'h0,
			64'h8000_0000_0000_0000);
		add_entry(fu_pkg::OP_CMPU, fu_pkg::CMB_AND, 64'h1, '1, 64'h6, 64'h6);
		add_entry(fu_pkg::OP_SGNJ, fu_pkg::CMB_AND, 64'h8000_0000_0000_0000,
			64'h4008_0000_0000_0000, 64'h0, 64'hC008_0000_0000_0000);
		add_entry(fu_pkg::OP_SGNJX, fu_pkg::CMB_AND, 64'hBFF0_0000_0000_0000,
			64'hC000_0000_0000_0001, 64'h0, 64'h4000_0000_0000_0001);
		// Back-pressure group of six single-cycle operations
		add_entry(fu_pkg::OP_CMOVZ, fu_pkg::CMB_AND, 64'h0, 64'hAAAA, 64'h5555, 64'hAAAA);
		add_entry(fu_pkg::OP_CMOVZ, fu_pkg::CMB_AND, 64'h1, 64'hAAAA, 64'h5555, 64'h5555);
		add_entry(fu_pkg::OP_CMOVNZ, fu_pkg::CMB_AND, 64'h0, 64'hAAAA, 64'h5555, 64'h5555);
		add_entry(fu_pkg::OP_CMOVNZ, fu_pkg::CMB_AND, 64'h8000_0000_0000_0000, 64'hAAAA,
			64'h5555, 64'hAAAA);
		add_entry(fu_pkg::OP_FABS, fu_pkg::CMB_AND, 64'hC000_0000_0000_0000, 64'h0, 64'h0,
			64'h4000_0000_0000_0000);
		add_entry(fu_pkg::OP_FNEG, fu_pkg::CMB_AND, 64'h3FF0_0000_0000_0000, 64'h0, 64'h0,
			64'hBFF0_0000_0000_0000);

		repeat (3) @(posedge clk);
		#10;
		rst = 1'b0;

		// Both ports stay quiet out of reset with nothing issued
		repeat (4) begin
			check_flag("issue_ack after reset", issue_ack, 1'b0);
			check_flag("result_req after reset", result_req, 1'b0);
			@(posedge clk);
			#10;
		end

		fork
			send_ops(0, BP_FIRST);
			collect_results(0, BP_FIRST, 1'b0);
		join

		fork
			send_ops(BP_FIRST, NUM);
			collect_results(BP_FIRST, NUM, 1'b1);
		join
		check_flag("queue full back-pressure seen", bp_cycles > 0, 1'b1);

		if (seen != NUM || issued != NUM || n_entries != NUM) begin
			$display("Checks failed");
			$fatal(1, "Only %0d of %0d results were received", seen, NUM);
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: verification/fu_sva.sv
module fu_sva (
	input logic                   clk,
	input logic                   rst,
	input logic                   issue_req,
	input logic                   issue_ack,
	input logic                   result_req,
	input logic                   result_ack,
	input logic [fu_pkg::WID-1:0] result_data,
	input logic                   wr_en,
	input logic                   full
);

	// ========================================================================
	// Four-phase issue and result ports
	// ========================================================================

	// An acknowledge only answers a request that was already up
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(issue_ack) |-> $past(issue_req))
		else $error("issue_ack rose without a pending issue_req");

	// Writeback sees one fixed value for the whole request phase
	data_stable: assert property (@(posedge clk) disable iff (rst)
		(result_req && $past(result_req)) |-> $stable(result_data))
		else $error("result_data changed while result_req was high");

	// The request is only released in answer to an acknowledge
	req_held: assert property (@(posedge clk) disable iff (rst)
		$fell(result_req) |-> $past(result_ack))
		else $error("result_req fell before result_ack was seen");

	// ========================================================================
	// Queue
	// ========================================================================

	no_write_full: assert property (@(posedge clk) disable iff (rst)
		!(wr_en && full))
		else $error("queue write while the queue is full");

endmodule

bind fu_top fu_sva sva0 (
	.clk(clk), .rst(rst),
	.issue_req(issue_req), .issue_ack(issue_ack),
	.result_req(result_req), .result_ack(result_ack), .result_data(result_data),
	.wr_en(wr_en), .full(full)
);

// File: source/fu_top.sv
module fu_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue_req,
	input  fu_pkg::op_t            issue_op,
	input  fu_pkg::cmb_t           issue_cmb,
	input  logic [fu_pkg::WID-1:0] issue_a,
	input  logic [fu_pkg::WID-1:0] issue_b,
	input  logic [fu_pkg::WID-1:0] issue_c,
	output logic                   issue_ack,
	output logic                   result_req,
	input  logic                   result_ack,
	output logic [fu_pkg::WID-1:0] result_data
);

	// Queue write side
	logic                   wr_en;
	fu_pkg::op_t            wr_op;
	fu_pkg::cmb_t           wr_cmb;
	logic [fu_pkg::WID-1:0] wr_a;
	logic [fu_pkg::WID-1:0] wr_b;
	logic [fu_pkg::WID-1:0] wr_c;
	logic                   full;

	// Queue read side
	logic                   rd_en;
	logic                   empty;
	fu_pkg::op_t            rd_op;
	fu_pkg::cmb_t           rd_cmb;
	logic [fu_pkg::WID-1:0] rd_a;
	logic [fu_pkg::WID-1:0] rd_b;
	logic [fu_pkg::WID-1:0] rd_c;

	issue_port u_issue_port (
		.clk(clk), .rst(rst),
		.issue_req(issue_req), .issue_op(issue_op), .issue_cmb(issue_cmb),
		.issue_a(issue_a), .issue_b(issue_b), .issue_c(issue_c),
		.full(full), .issue_ack(issue_ack),
		.wr_en(wr_en), .wr_op(wr_op), .wr_cmb(wr_cmb),
		.wr_a(wr_a), .wr_b(wr_b), .wr_c(wr_c)
	);

	op_queue u_op_queue (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_op(wr_op), .wr_cmb(wr_cmb),
		.wr_a(wr_a), .wr_b(wr_b), .wr_c(wr_c),
		.rd_en(rd_en), .full(full), .empty(empty),
		.rd_op(rd_op), .rd_cmb(rd_cmb), .rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c)
	);

	exec_unit u_exec_unit (
		.clk(clk), .rst(rst),
		.empty(empty), .rd_op(rd_op), .rd_cmb(rd_cmb),
		.rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c), .rd_en(rd_en),
		.result_req(result_req), .result_ack(result_ack), .result_data(result_data)
	);

endmodule

// File: source/exec_unit.sv
module exec_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   empty,
	input  fu_pkg::op_t            rd_op,
	input  fu_pkg::cmb_t           rd_cmb,
	input  logic [fu_pkg::WID-1:0] rd_a,
	input  logic [fu_pkg::WID-1:0] rd_b,
	input  logic [fu_pkg::WID-1:0] rd_c,
	output logic                   rd_en,
	output logic                   result_req,
	input  logic                   result_ack,
	output logic [fu_pkg::WID-1:0] result_data
);

	fu_pkg::ex_state_t      state;
	logic [fu_pkg::WID-1:0] logic_y;
	logic [fu_pkg::WID-1:0] mul_product;
	logic                   mul_start;
	logic                   mul_done;

	// ========================================================================
	// Compute units
	// ========================================================================

	// Works straight off the queue head, so the result is ready at the pop edge
	op_logic u_op_logic (
		.op  (rd_op),
		.cmb (rd_cmb),
		.a   (rd_a),
		.b   (rd_b),
		.c   (rd_c),
		.y   (logic_y)
	);

	iter_mul u_iter_mul (
		.clk      (clk),
		.rst      (rst),
		.start    (mul_start),
		.a        (rd_a),
		.b        (rd_b),
		.product  (mul_product),
		.mul_done (mul_done)
	);

	// ========================================================================
	// Control
	// ========================================================================

	// Pop whenever idle and something is waiting
	assign rd_en = (state == fu_pkg::EX_IDLE) && !empty;

	// Multiply operands are taken on the pop edge
	assign mul_start = rd_en && (rd_op == fu_pkg::OP_MUL);

	assign result_req = (state == fu_pkg::EX_HOLD);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fu_pkg::EX_IDLE;
		end else begin
			case (state)
				fu_pkg::EX_IDLE: begin
					if (rd_en)
						state <= mul_start ? fu_pkg::EX_BUSY : fu_pkg::EX_HOLD;
				end
				fu_pkg::EX_BUSY: begin
					if (mul_done)
						state <= fu_pkg::EX_HOLD;
				end
				fu_pkg::EX_HOLD: begin
					// Request drops the cycle after the acknowledge is seen
					if (result_ack)
						state <= fu_pkg::EX_DROP;
				end
				fu_pkg::EX_DROP: begin
					// Four-phase return, next pop only after ack is back low
					if (!result_ack)
						state <= fu_pkg::EX_IDLE;
				end
				default: state <= fu_pkg::EX_IDLE;
			endcase
		end
	end

	// Result holds still from capture until the next capture, covering the request phase
	always_ff @(posedge clk) begin
		if (rd_en && !mul_start)
			result_data <= logic_y;
		else if (state == fu_pkg::EX_BUSY && mul_done)
			result_data <= mul_product;
	end

endmodule

// File: source/iter_mul.sv
module iter_mul (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  logic [fu_pkg::WID-1:0] a,
	input  logic [fu_pkg::WID-1:0] b,
	output logic [fu_pkg::WID-1:0] product,
	output logic                   mul_done
);

	logic [fu_pkg::WID-1:0]       mcand;
	logic [fu_pkg::WID-1:0]       mplier;
	logic [fu_pkg::WID-1:0]       acc;
	logic [fu_pkg::MUL_CNT_W-1:0] step_cnt;
	logic                         busy;

	assign product = acc;

	// Control state
	// The run ends on the first busy cycle that finds no multiplier bits left
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			mul_done <= 1'b0;
			step_cnt <= '0;
		end else begin
			mul_done <= 1'b0;
			if (start) begin
				busy     <= 1'b1;
				step_cnt <= '0;
			end else if (busy) begin
				if (mplier == 0 || step_cnt == fu_pkg::MUL_STEPS) begin
					busy     <= 1'b0;
					mul_done <= 1'b1;
				end else begin
					step_cnt <= step_cnt + 1'b1;
				end
			end
		end
	end

	// Datapath, one multiplier bit retired per cycle
	// Bits shifted past the top of mcand fall out, leaving the low half of the product
	always_ff @(posedge clk) begin
		if (start) begin
			mcand  <= a;
			mplier <= b;
			acc    <= '0;
		end else if (busy && mplier != 0) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

// File: source/op_logic.sv
module op_logic (
	input  fu_pkg::op_t            op,
	input  fu_pkg::cmb_t           cmb,
	input  logic [fu_pkg::WID-1:0] a,
	input  logic [fu_pkg::WID-1:0] b,
	input  logic [fu_pkg::WID-1:0] c,
	output logic [fu_pkg::WID-1:0] y
);

	logic [fu_pkg::WID-1:0] first;
	logic [fu_pkg::WID-1:0] merged;
	logic [fu_pkg::WID-1:0] cmp_vec;
	logic                   eq;
	logic                   lt;
	logic                   le;
	logic                   a_nz;

	// ========================================================================
	// Compare
	// ========================================================================

	// Same equality for both compares, only the ordering depends on signedness
	always_comb begin
		eq = (a == b);
		if (op == fu_pkg::OP_CMP)
			lt = ($signed(a) < $signed(b));
		else
			lt = (a < b);
		le = lt | eq;
	end

	// Flags sit in the low three bits, the rest reads as zero
	assign cmp_vec = {{(fu_pkg::WID - 3){1'b0}}, le, lt, eq};

	// ========================================================================
	// First result and merge with c
	// ========================================================================

	always_comb begin
		case (op)
			fu_pkg::OP_ADD:  first = a + b;
			fu_pkg::OP_AND:  first = a & b;
			fu_pkg::OP_OR:   first = a | b;
			fu_pkg::OP_EOR:  first = a ^ b;
			fu_pkg::OP_CMP,
			fu_pkg::OP_CMPU: first = cmp_vec;
			default:         first = '0;
		endcase
	end

	// The combine selector applies to every opcode that forms a first result
	always_comb begin
		case (cmb)
			fu_pkg::CMB_AND: merged = first & c;
			fu_pkg::CMB_OR:  merged = first | c;
			fu_pkg::CMB_EOR: merged = first ^ c;
			fu_pkg::CMB_ADD: merged = first + c;
			default:         merged = first;
		endcase
	end

	// ========================================================================
	// Result select
	// ========================================================================

	assign a_nz = |a;

	always_comb begin
		case (op)
			fu_pkg::OP_ADD,
			fu_pkg::OP_AND,
			fu_pkg::OP_OR,
			fu_pkg::OP_EOR,
			fu_pkg::OP_CMP,
			fu_pkg::OP_CMPU:   y = merged;
			fu_pkg::OP_SUB:    y = a - b - c;
			// Each bit takes the value held by at least two of the three operands
			fu_pkg::OP_MAJ:    y = (a & b) | (a & c) | (b & c);
			// A nonzero a selects c for cmovz and b for cmovnz
			fu_pkg::OP_CMOVZ:  y = a_nz ? c : b;
			fu_pkg::OP_CMOVNZ: y = a_nz ? b : c;
			// Sign operations touch only the top bit of a double
			fu_pkg::OP_FABS:   y = {1'b0, a[fu_pkg::WID-2:0]};
			fu_pkg::OP_FNEG:   y = {~a[fu_pkg::WID-1], a[fu_pkg::WID-2:0]};
			fu_pkg::OP_SGNJ:   y = {a[fu_pkg::WID-1], b[fu_pkg::WID-2:0]};
			fu_pkg::OP_SGNJX:  y = {a[fu_pkg::WID-1] ^ b[fu_pkg::WID-1], b[fu_pkg::WID-2:0]};
			// Multiply comes from the iterative unit instead
			default:           y = '0;
		endcase
	end

endmodule

// File: source/op_queue.sv
module op_queue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wr_en,
	input  fu_pkg::op_t            wr_op,
	input  fu_pkg::cmb_t           wr_cmb,
	input  logic [fu_pkg::WID-1:0] wr_a,
	input  logic [fu_pkg::WID-1:0] wr_b,
	input  logic [fu_pkg::WID-1:0] wr_c,
	input  logic                   rd_en,
	output logic                   full,
	output logic                   empty,
	output fu_pkg::op_t            rd_op,
	output fu_pkg::cmb_t           rd_cmb,
	output logic [fu_pkg::WID-1:0] rd_a,
	output logic [fu_pkg::WID-1:0] rd_b,
	output logic [fu_pkg::WID-1:0] rd_c
);

	// Entry storage, one array per field
	fu_pkg::op_t            q_op  [fu_pkg::QUEUE_DEPTH];
	fu_pkg::cmb_t           q_cmb [fu_pkg::QUEUE_DEPTH];
	logic [fu_pkg::WID-1:0] q_a   [fu_pkg::QUEUE_DEPTH];
	logic [fu_pkg::WID-1:0] q_b   [fu_pkg::QUEUE_DEPTH];
	logic [fu_pkg::WID-1:0] q_c   [fu_pkg::QUEUE_DEPTH];

	logic [fu_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [fu_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [fu_pkg::QUEUE_CNT_W-1:0] count;
	logic                           do_wr;
	logic                           do_rd;

	assign full  = (count == fu_pkg::QUEUE_DEPTH);
	assign empty = (count == 0);

	// A pop frees the head slot on the same edge, so a full queue can still take a write
	assign do_rd = rd_en && !empty;
	assign do_wr = wr_en && (!full || do_rd);

	// Head entry shows without waiting for a clock edge
	assign rd_op  = q_op[rd_ptr];
	assign rd_cmb = q_cmb[rd_ptr];
	assign rd_a   = q_a[rd_ptr];
	assign rd_b   = q_b[rd_ptr];
	assign rd_c   = q_c[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			q_op[wr_ptr]  <= wr_op;
			q_cmb[wr_ptr] <= wr_cmb;
			q_a[wr_ptr]   <= wr_a;
			q_b[wr_ptr]   <= wr_b;
			q_c[wr_ptr]   <= wr_c;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy is unchanged when a write and a pop coincide
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// File: source/issue_port.sv
module issue_port (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issue_req,
	input  fu_pkg::op_t            issue_op,
	input  fu_pkg::cmb_t           issue_cmb,
	input  logic [fu_pkg::WID-1:0] issue_a,
	input  logic [fu_pkg::WID-1:0] issue_b,
	input  logic [fu_pkg::WID-1:0] issue_c,
	input  logic                   full,
	output logic                   issue_ack,
	output logic                   wr_en,
	output fu_pkg::op_t            wr_op,
	output fu_pkg::cmb_t           wr_cmb,
	output logic [fu_pkg::WID-1:0] wr_a,
	output logic [fu_pkg::WID-1:0] wr_b,
	output logic [fu_pkg::WID-1:0] wr_c
);

	fu_pkg::iss_state_t state;

	// The sender holds its fields stable for the whole transaction,
	// so they go to the queue as they are
	assign wr_op  = issue_op;
	assign wr_cmb = issue_cmb;
	assign wr_a   = issue_a;
	assign wr_b   = issue_b;
	assign wr_c   = issue_c;

	// Only the idle state can accept, and only with room in the queue
	// A request held high in ISS_DROP is never written again
	assign wr_en = (state == fu_pkg::ISS_IDLE) && issue_req && !full;

	// Acknowledge is high for exactly the time spent in ISS_DROP
	assign issue_ack = (state == fu_pkg::ISS_DROP);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fu_pkg::ISS_IDLE;
		end else begin
			case (state)
				fu_pkg::ISS_IDLE: begin
					// While the queue is full the acknowledge is withheld
					if (issue_req && !full)
						state <= fu_pkg::ISS_DROP;
				end
				fu_pkg::ISS_DROP: begin
					// Wait for the sender to release its request
					if (!issue_req)
						state <= fu_pkg::ISS_IDLE;
				end
				default: state <= fu_pkg::ISS_IDLE;
			endcase
		end
	end

endmodule

// File: source/fu_pkg.sv
package fu_pkg;

	// ========================================================================
	// Widths and sizes
	// ========================================================================

	// Operand and result width, the sign operations work on bit 63
	localparam int WID = 64;

	// Operation queue between the issue port and the execution unit
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = 2;
	// Occupancy needs one more bit than a pointer so that full can be told from empty
	localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

	// Worst case multiply iterations, one per multiplier bit
	localparam int MUL_STEPS = 64;
	localparam int MUL_CNT_W = 7;

	// ========================================================================
	// Operation encodings
	// ========================================================================

	// Operations arrive already decoded from the issue stage
	typedef enum logic [3:0] {
		OP_ADD    = 4'd0,
		OP_AND    = 4'd1,
		OP_OR     = 4'd2,
		OP_EOR    = 4'd3,
		OP_SUB    = 4'd4,
		OP_MAJ    = 4'd5,
		OP_CMP    = 4'd6,
		OP_CMPU   = 4'd7,
		OP_CMOVZ  = 4'd8,
		OP_CMOVNZ = 4'd9,
		OP_FABS   = 4'd10,
		OP_FNEG   = 4'd11,
		OP_SGNJ   = 4'd12,
		OP_SGNJX  = 4'd13,
		OP_MUL    = 4'd14
	} op_t;

	// How the first result is merged with the third operand
	typedef enum logic [1:0] {
		CMB_AND = 2'd0,
		CMB_OR  = 2'd1,
		CMB_EOR = 2'd2,
		CMB_ADD = 2'd3
	} cmb_t;

	// Issue side receiver states
	typedef enum logic {
		ISS_IDLE = 1'b0,
		ISS_DROP = 1'b1
	} iss_state_t;

	// Execution unit states
	typedef enum logic [1:0] {
		EX_IDLE = 2'd0,
		EX_BUSY = 2'd1,
		EX_HOLD = 2'd2,
		EX_DROP = 2'd3
	} ex_state_t;

endpackage
